//--- hdl/decode_control.sv
module decode_control import decode_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       mode_32bit,
    decode_window_if.control win,
    decode_ready_if.control_side rdy,
    output logic       pop_valid,
    output logic [3:0] pop_count,
    output logic       instr_valid,
    input  logic       instr_ready,
    output logic [3:0] instr_length,
    output logic [7:0] instr_opcode,
    output logic       instr_two_byte,
    output logic       instr_operand_32,
    output logic       instr_address_32
);

    logic [7:0] op;
    logic [2:0] modrm_reg;
    logic counted;
    logic operand_ovr;
    logic address_ovr;
    logic [count_bits-1:0] pfx_count;
    len_class_e cls;
    logic cls_ready;
    logic take;
    logic enable;

    assign op = win.window[7:0];
    assign modrm_reg = win.window[13:11];

    // Lock, repeat and segment prefixes
    always_comb begin
        counted = 1'b0;
        for (int i = 0; i < pfx_counted_num; i++) begin
            if (op == pfx_counted[i]) counted = 1'b1;
        end
    end

    // No prefixes inside the two-byte map
    assign win.is_prefix = !win.prefix_2byte && win.count != '0 &&
                           (op == pfx_operand || op == pfx_address || op == pfx_escape || counted);

    // Prefixes flip the mode default
    assign win.operand_32 = mode_32bit ^ operand_ovr;
    assign win.address_32 = mode_32bit ^ address_ovr;

    // Opcode to length class
    always_comb begin
        if (win.is_prefix || win.count == '0) begin
            cls = cls_none;
        end else if (win.prefix_2byte) begin
            if (op[7:4] == 4'h8) begin
                // Jcc rel16/32
                cls = cls_2byte_imm;
            end else if (op[7:2] == 6'b000000 || op[7:4] == 4'h4 || op[7:4] == 4'h9 ||
                         op == 8'hA3 || op == 8'hA5 || op == 8'hAB || op == 8'hAD ||
                         op == 8'hAF || op[7:4] == 4'hB || op[7:1] == 7'b1100000) begin
                cls = cls_2byte_modregrm;
            end else begin
                cls = cls_2byte_one;
            end
        end else begin
            casez (op)
                8'b00??_?10?, 8'h68, 8'h6A, 8'hA8, 8'hA9, 8'hB?: cls = cls_one_imm;
                8'b00??_?0??, 8'h62, 8'h63, 8'b1000_01??, 8'b1000_1???,
                8'hC4, 8'hC5, 8'b1101_00??, 8'b1101_1???, 8'hFE, 8'hFF:
                    cls = cls_modregrm;
                8'b1000_00??, 8'h69, 8'h6B, 8'hC0, 8'hC1, 8'hC6, 8'hC7:
                    cls = cls_modregrm_imm;
                // TEST r/m, imm only with reg field 0
                8'hF6, 8'hF7: cls = (modrm_reg == 3'd0) ? cls_modregrm_imm : cls_modregrm;
                8'hE8, 8'hE9, 8'hEA, 8'hEB, 8'h9A: cls = cls_call_jmp_imm;
                8'b1010_00??: cls = cls_mem_offset;
                8'h7?, 8'hCD, 8'hD4, 8'hD5, 8'b1110_0???: cls = cls_one_one;
                8'hC2, 8'hCA: cls = cls_one_two;
                8'hC8: cls = cls_one_three;
                default: cls = cls_one;
            endcase
        end
    end

    // Ready bit of the requested class
    always_comb begin
        case (cls)
            cls_one:            cls_ready = rdy.ready.dec_ready_one;
            cls_one_one:        cls_ready = rdy.ready.dec_ready_one_one;
            cls_one_two:        cls_ready = rdy.ready.dec_ready_one_two;
            cls_one_three:      cls_ready = rdy.ready.dec_ready_one_three;
            cls_call_jmp_imm:   cls_ready = rdy.ready.dec_ready_call_jmp_imm;
            cls_one_imm:        cls_ready = rdy.ready.dec_ready_one_imm;
            cls_mem_offset:     cls_ready = rdy.ready.dec_ready_mem_offset;
            cls_modregrm:       cls_ready = rdy.ready.dec_ready_modregrm_one;
            cls_modregrm_imm:   cls_ready = rdy.ready.dec_ready_modregrm_imm;
            cls_2byte_one:      cls_ready = rdy.ready.dec_ready_2byte_one;
            cls_2byte_modregrm: cls_ready = rdy.ready.dec_ready_2byte_modregrm;
            cls_2byte_imm:      cls_ready = rdy.ready.dec_ready_2byte_imm;
            default:            cls_ready = 1'b0;
        endcase
    end

    // Output register free or being emptied this cycle
    assign enable = !instr_valid || instr_ready;
    assign rdy.enable = enable;
    assign rdy.consume_class = cls;

    // ModR/M length is trusted only with its byte present
    assign take = cls_ready && (!rdy.is_modregrm || win.count >= 4'd2);

    assign pop_valid = enable && (win.is_prefix || take);
    assign pop_count = win.is_prefix ? 4'd1 : rdy.consume_count;

    // Prefix run state, cleared when the body leaves
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operand_ovr <= 1'b0;
            address_ovr <= 1'b0;
            win.prefix_2byte <= 1'b0;
            pfx_count <= '0;
        end else if (take) begin
            operand_ovr <= 1'b0;
            address_ovr <= 1'b0;
            win.prefix_2byte <= 1'b0;
            pfx_count <= '0;
        end else if (enable && win.is_prefix) begin
            pfx_count <= pfx_count + 4'd1;
            if (op == pfx_operand) operand_ovr <= 1'b1;
            if (op == pfx_address) address_ovr <= 1'b1;
            if (op == pfx_escape) win.prefix_2byte <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_valid <= 1'b0;
        end else if (take) begin
            instr_valid <= 1'b1;
        end else if (instr_ready) begin
            instr_valid <= 1'b0;
        end
    end

    // Record fields, held until accepted
    always_ff @(posedge clk) begin
        if (take) begin
            instr_length <= pfx_count + rdy.consume_count;
            instr_opcode <= op;
            instr_two_byte <= win.prefix_2byte;
            instr_operand_32 <= win.operand_32;
            instr_address_32 <= win.address_32;
        end
    end

endmodule

//--- hdl/decode_pkg.sv
package decode_pkg;

    // Queue and window geometry
    localparam int window_bytes = 12;
    localparam int queue_depth = 16;
    localparam int count_bits = 4;

    // Prefix bytes that change decode state
    localparam logic [7:0] pfx_operand = 8'h66;
    localparam logic [7:0] pfx_address = 8'h67;
    localparam logic [7:0] pfx_escape = 8'h0F;

    // Lock, repeat and segment prefixes, only counted
    localparam int pfx_counted_num = 9;
    localparam logic [7:0] pfx_counted [pfx_counted_num] = '{
        8'hF0, 8'hF2, 8'hF3, 8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65
    };

    // One member per consume class of the length stage
    typedef enum logic [3:0] {
        cls_one,
        cls_one_one,
        cls_one_two,
        cls_one_three,
        cls_call_jmp_imm,
        cls_one_imm,
        cls_mem_offset,
        cls_modregrm,
        cls_modregrm_imm,
        cls_2byte_one,
        cls_2byte_modregrm,
        cls_2byte_imm,
        cls_none
    } len_class_e;

    // Whole instruction present for each class
    typedef struct packed {
        logic dec_ready_one;
        logic dec_ready_one_one;
        logic dec_ready_one_two;
        logic dec_ready_one_three;
        logic dec_ready_2byte_one;
        logic dec_ready_modregrm_one;
        logic dec_ready_2byte_modregrm;
        logic dec_ready_call_jmp_imm;
        logic dec_ready_one_imm;
        logic dec_ready_2byte_imm;
        logic dec_ready_mem_offset;
        logic dec_ready_modregrm_imm;
        logic dec_ready_2byte_modregrm_imm;
    } dec_ready_t;

endpackage

//--- hdl/decode_ready.sv
module decode_ready import decode_pkg::*; (
    decode_window_if.reader win,
    input logic [2:0] modregrm_len,
    decode_ready_if.ready_side rdy
);

    logic [7:0] op;
    logic one_ok;
    logic esc_ok;
    logic [count_bits-1:0] cnt;
    logic [2:0] call_jmp_imm_len;
    logic [2:0] one_imm_len;
    logic [2:0] mem_offset_len;
    logic [2:0] imm_only_len;
    logic [count_bits-1:0] modregrm_imm_len;

    assign op = win.window[7:0];
    assign cnt = win.count;

    // One-byte map needs a settled prefix run
    assign one_ok = rdy.enable && !win.is_prefix && !win.prefix_2byte;
    // Two-byte map needs the escape already taken
    assign esc_ok = rdy.enable && win.prefix_2byte;

    // EB short, 9A and EA far pointer, E8 and E9 near
    always_comb begin
        if (op[1:0] == 2'b11) begin
            call_jmp_imm_len = 3'd2;
        end else if (op[1]) begin
            call_jmp_imm_len = win.operand_32 ? 3'd7 : 3'd5;
        end else begin
            call_jmp_imm_len = win.operand_32 ? 3'd5 : 3'd3;
        end
    end

    // Byte immediates for MOV r8, TEST AL, PUSH imm8 and ALU AL forms
    always_comb begin
        if (!win.prefix_2byte && (op[7:3] == 5'b10110 || op == 8'hA8 || op == 8'h6A ||
                                  {op[7:6], op[0]} == 3'b000)) begin
            one_imm_len = 3'd2;
        end else begin
            // Word immediates, and rel16 or rel32 of two-byte Jcc
            one_imm_len = win.operand_32 ? 3'd5 : 3'd3;
        end
    end

    // moffs width follows address size
    assign mem_offset_len = win.address_32 ? 3'd5 : 3'd3;

    // imm8 for 80, 82, 83, 6B, C0, C1, C6, F6, word immediate otherwise
    always_comb begin
        if (win.prefix_2byte || op[7:1] == 7'b1100000 || op[1:0] == 2'b00 ||
            op[1:0] == 2'b10 || op[2:0] == 3'b011) begin
            imm_only_len = 3'd1;
        end else begin
            imm_only_len = win.operand_32 ? 3'd4 : 3'd2;
        end
    end

    assign modregrm_imm_len = {1'b0, modregrm_len} + {1'b0, imm_only_len};

    // Ready once the queue holds the whole class length
    always_comb begin
        rdy.ready.dec_ready_one = one_ok && cnt >= 4'd1;
        rdy.ready.dec_ready_one_one = one_ok && cnt >= 4'd2;
        rdy.ready.dec_ready_one_two = one_ok && cnt >= 4'd3;
        rdy.ready.dec_ready_one_three = one_ok && cnt >= 4'd4;
        rdy.ready.dec_ready_2byte_one = esc_ok && cnt >= 4'd1;
        rdy.ready.dec_ready_modregrm_one = one_ok && cnt >= {1'b0, modregrm_len};
        rdy.ready.dec_ready_2byte_modregrm = esc_ok && cnt >= {1'b0, modregrm_len};
        rdy.ready.dec_ready_call_jmp_imm = one_ok && cnt >= {1'b0, call_jmp_imm_len};
        rdy.ready.dec_ready_one_imm = one_ok && cnt >= {1'b0, one_imm_len};
        rdy.ready.dec_ready_2byte_imm = esc_ok && cnt >= {1'b0, one_imm_len};
        rdy.ready.dec_ready_mem_offset = one_ok && cnt >= {1'b0, mem_offset_len};
        rdy.ready.dec_ready_modregrm_imm = one_ok && cnt >= modregrm_imm_len;
        rdy.ready.dec_ready_2byte_modregrm_imm = esc_ok && cnt >= modregrm_imm_len;
    end

    // Body length of the class being asked for
    always_comb begin
        case (rdy.consume_class)
            cls_one, cls_2byte_one:         rdy.consume_count = 4'd1;
            cls_one_one:                    rdy.consume_count = 4'd2;
            cls_one_two:                    rdy.consume_count = 4'd3;
            cls_one_three:                  rdy.consume_count = 4'd4;
            cls_call_jmp_imm:               rdy.consume_count = {1'b0, call_jmp_imm_len};
            cls_one_imm, cls_2byte_imm:     rdy.consume_count = {1'b0, one_imm_len};
            cls_mem_offset:                 rdy.consume_count = {1'b0, mem_offset_len};
            cls_modregrm, cls_2byte_modregrm: rdy.consume_count = {1'b0, modregrm_len};
            cls_modregrm_imm:               rdy.consume_count = modregrm_imm_len;
            default:                        rdy.consume_count = 4'd0;
        endcase
    end

    assign rdy.is_modregrm = (rdy.consume_class == cls_modregrm) ||
                             (rdy.consume_class == cls_modregrm_imm);

endmodule

//--- hdl/decode_ready_if.sv
interface decode_ready_if import decode_pkg::*; ();

    // Per-class readiness
    dec_ready_t ready;
    // Bytes taken by consume_class, prefixes excluded
    logic [count_bits-1:0] consume_count;
    logic is_modregrm;

    // Output register free or draining
    logic enable;
    len_class_e consume_class;

    modport ready_side (
        input enable, consume_class,
        output ready, consume_count, is_modregrm
    );

    modport control_side (
        output enable, consume_class,
        input ready, consume_count, is_modregrm
    );

endinterface

//--- hdl/decode_window_if.sv
interface decode_window_if import decode_pkg::*; ();

    // Byte 0 is the oldest byte, little-endian order
    logic [window_bytes*8-1:0] window;
    // Valid bytes in the window, saturated
    logic [count_bits-1:0] count;

    // Prefix state from the control block
    logic is_prefix;
    logic prefix_2byte;
    logic operand_32;
    logic address_32;

    modport queue (output window, count);

    modport control (
        input window, count,
        output is_prefix, prefix_2byte, operand_32, address_32
    );

    modport reader (
        input window, count, is_prefix, prefix_2byte, operand_32, address_32
    );

endinterface

//--- hdl/fetch_queue.sv
module fetch_queue import decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  logic [31:0] fetch_data,
    input  logic        pop_valid,
    input  logic [3:0]  pop_count,
    decode_window_if.queue win
);

    localparam int used_bits = $clog2(queue_depth + 1);

    logic [7:0] mem [queue_depth];
    logic [used_bits-1:0] used;
    logic [used_bits-1:0] pop_n;
    logic [used_bits-1:0] after_pop;
    logic started;
    logic push;

    // Bytes left once this cycle's pop is done
    assign pop_n = pop_valid ? used_bits'(pop_count) : '0;
    assign after_pop = used - pop_n;

    // Room for a whole fetch word behind the remaining bytes
    assign fetch_ready = started && (queue_depth - int'(after_pop) >= 4);
    assign push = fetch_valid && fetch_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            used <= '0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            used <= after_pop + (push ? used_bits'(4) : '0);
        end
    end

    // Shift down by the pop and append the new word behind the survivors
    always_ff @(posedge clk) begin
        for (int i = 0; i < queue_depth; i++) begin
            if (i + int'(pop_n) < int'(used)) begin
                mem[i] <= mem[i + int'(pop_n)];
            end else if (push && i >= int'(after_pop) && i < int'(after_pop) + 4) begin
                mem[i] <= fetch_data[(i - int'(after_pop))*8 +: 8];
            end
        end
    end

    // Oldest bytes form the decode window
    always_comb begin
        for (int b = 0; b < window_bytes; b++) begin
            win.window[b*8 +: 8] = mem[b];
        end
    end

    // Count saturates at the window size
    assign win.count = (int'(used) >= window_bytes) ? count_bits'(window_bytes)
                                                     : count_bits'(used);

endmodule

//--- hdl/instr_length_top.sv
module instr_length_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mode_32bit,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  logic [31:0] fetch_data,
    output logic        instr_valid,
    input  logic        instr_ready,
    output logic [3:0]  instr_length,
    output logic [7:0]  instr_opcode,
    output logic        instr_two_byte,
    output logic        instr_operand_32,
    output logic        instr_address_32
);

    logic       pop_valid;
    logic [3:0] pop_count;
    logic [2:0] modregrm_len_w;

    decode_window_if win_if ();
    decode_ready_if rdy_if ();

    // Byte queue and decode window
    fetch_queue u_fetch_queue (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .pop_valid   (pop_valid),
        .pop_count   (pop_count),
        .win         (win_if.queue)
    );

    modregrm_len u_modregrm_len (
        .win          (win_if.reader),
        .modregrm_len (modregrm_len_w)
    );

    decode_ready u_decode_ready (
        .win          (win_if.reader),
        .modregrm_len (modregrm_len_w),
        .rdy          (rdy_if.ready_side)
    );

    // Prefixes, classes and the record register
    decode_control u_decode_control (
        .clk              (clk),
        .arst_n           (arst_n),
        .mode_32bit       (mode_32bit),
        .win              (win_if.control),
        .rdy              (rdy_if.control_side),
        .pop_valid        (pop_valid),
        .pop_count        (pop_count),
        .instr_valid      (instr_valid),
        .instr_ready      (instr_ready),
        .instr_length     (instr_length),
        .instr_opcode     (instr_opcode),
        .instr_two_byte   (instr_two_byte),
        .instr_operand_32 (instr_operand_32),
        .instr_address_32 (instr_address_32)
    );

endmodule

//--- hdl/modregrm_len.sv
module modregrm_len import decode_pkg::*; (
    decode_window_if.reader win,
    output logic [2:0] modregrm_len
);

    logic [1:0] md;
    logic [2:0] rm;
    logic [2:0] sib_base;

    // ModR/M follows the opcode, SIB follows the ModR/M
    assign md = win.window[15:14];
    assign rm = win.window[10:8];
    assign sib_base = win.window[18:16];

    // Count includes opcode and ModR/M bytes
    always_comb begin
        if (md == 2'b11) begin
            // Register operand
            modregrm_len = 3'd2;
        end else if (!win.address_32) begin
            // 16-bit forms, rm 110 with mod 00 is disp16 only
            case (md)
                2'b00:   modregrm_len = (rm == 3'd6) ? 3'd4 : 3'd2;
                2'b01:   modregrm_len = 3'd3;
                default: modregrm_len = 3'd4;
            endcase
        end else begin
            // 32-bit forms, rm 100 brings a SIB byte
            case (md)
                2'b00: begin
                    if (rm == 3'd5) begin
                        modregrm_len = 3'd6;
                    end else if (rm == 3'd4) begin
                        // SIB base 101 without disp means disp32
                        modregrm_len = (sib_base == 3'd5) ? 3'd7 : 3'd3;
                    end else begin
                        modregrm_len = 3'd2;
                    end
                end
                2'b01:   modregrm_len = (rm == 3'd4) ? 3'd4 : 3'd3;
                default: modregrm_len = (rm == 3'd4) ? 3'd7 : 3'd6;
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the instruction length testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_instr_length -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_instr_length)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

//--- sources.f
hdl/decode_pkg.sv
hdl/decode_window_if.sv
hdl/decode_ready_if.sv
hdl/fetch_queue.sv
hdl/modregrm_len.sv
hdl/decode_ready.sv
hdl/decode_control.sv
hdl/instr_length_top.sv
test/tb_instr_length.sv

//--- test/instr_input.txt
# T mode name, then W count and hex fetch words, byte 0 in bits 7:0
# E count, then per record: length opcode flags (two_byte op32 addr32)
# Fixed length classes, 16-bit
T 0 fixed
W 3 C221CD90 10C80004 90900100
E 6 1 90 000 2 CD 000 3 C2 000 4 C8 000 1 90 000 1 90 000
# Size-dependent immediates, 16-bit
T 0 imm16
W 6 EB1234E8 0000EAFE 34B8F000 56786812 00A1016A 90909010
E 5 3 E8 000 2 EB 000 5 EA 000 3 B8 000 3 68 000
E 5 2 6A 000 3 A1 000 1 90 000 1 90 000 1 90 000
# Size-dependent immediates, 32-bit
T 1 imm32
W 4 000000E8 EA00EB00 00000000 01B80000
W 4 68000000 00000002 00A1036A 90000000
E 4 5 E8 011 2 EB 011 7 EA 011 5 B8 011
E 4 5 68 011 2 6A 011 5 A1 011 1 90 011
# 66 and 67 raise sizes, F3 only counted
T 0 prefix_up
W 6 0000E866 A1670000 00000000 F3016A66 B86766A4 00000001
E 5 6 E8 010 6 A1 001 3 6A 010 2 A4 000 7 B8 011
# 66 and 67 lower sizes in 32-bit mode
T 1 prefix_down
W 3 1234B866 1000A167 1000E866
E 3 4 B8 001 4 A1 010 4 E8 001
# ModR/M with 16-bit forms, SIB with disp32 under 67
T 0 modrm
W 6 1234068B 8108468B 831234C0 8B6701C0 01002484 D8890000
E 6 4 8B 000 3 8B 000 4 81 000 3 83 000 8 8B 001 2 89 000
# Two-byte map through the 0F escape
T 0 two_byte
W 4 AF0FA20F FE840FC0 840F66FF 00000100
E 4 2 A2 100 3 AF 100 4 84 100 7 84 110

//--- test/tb_instr_length.sv
module tb_instr_length;

    logic        clk;
    logic        arst_n;
    logic        mode_32bit;
    logic        fetch_valid;
    logic        fetch_ready;
    logic [31:0] fetch_data;
    logic        instr_valid;
    logic        instr_ready;
    logic [3:0]  instr_length;
    logic [7:0]  instr_opcode;
    logic        instr_two_byte;
    logic        instr_operand_32;
    logic        instr_address_32;

    // Test table taken from the input file
    logic [127:0] test_name [16];
    logic         test_mode [16];
    int           word_first [16];
    int           word_num [16];
    int           rec_first [16];
    int           rec_num [16];
    int           num_tests;
    logic [31:0]  word_q [$];
    // Expected record as length, opcode, two_byte, op32, addr32
    logic [14:0]  exp_rec [$];

    int          check_errors;
    int          failed_tests;
    logic        load_done;
    logic [31:0] seed_val;

    instr_length_top dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .mode_32bit       (mode_32bit),
        .fetch_valid      (fetch_valid),
        .fetch_ready      (fetch_ready),
        .fetch_data       (fetch_data),
        .instr_valid      (instr_valid),
        .instr_ready      (instr_ready),
        .instr_length     (instr_length),
        .instr_opcode     (instr_opcode),
        .instr_two_byte   (instr_two_byte),
        .instr_operand_32 (instr_operand_32),
        .instr_address_32 (instr_address_32)
    );

    always #5 clk = ~clk;

    task automatic load_input();
        int fd;
        int code;
        int m;
        int n;
        int v1;
        int v2;
        int v3;
        int cur;
        logic [31:0] word_val;
        logic [7:0] tag;
        logic [127:0] name_buf;
        logic [8*100-1:0] line_buf;
        cur = -1;
        fd = $fopen("test/instr_input.txt", "r");
        if (fd == 0) begin
            $display("Input file test/instr_input.txt could not be opened");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(line_buf, fd);
                end else if (tag == "T" && num_tests < 16) begin
                    code = $fscanf(fd, "%d %s", m, name_buf);
                    cur = num_tests;
                    test_name[cur] = name_buf;
                    test_mode[cur] = (m != 0);
                    word_first[cur] = word_q.size();
                    word_num[cur] = 0;
                    rec_first[cur] = exp_rec.size();
                    rec_num[cur] = 0;
                    num_tests++;
                end else if (tag == "W" && cur >= 0) begin
                    code = $fscanf(fd, "%d", n);
                    for (int i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%h", word_val);
                        word_q.push_back(word_val);
                    end
                    word_num[cur] += n;
                end else if (tag == "E" && cur >= 0) begin
                    code = $fscanf(fd, "%d", n);
                    for (int i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%d %h %b", v1, v2, v3);
                        exp_rec.push_back({v1[3:0], v2[7:0], v3[2:0]});
                    end
                    rec_num[cur] += n;
                end else begin
                    $display("Input file holds a line that is not a test, word or record line");
                    check_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_field(input logic [127:0] name, input int k, input string field,
                               input int got, input int want);
        assert (got == want) else begin
            $display("FAIL %0t: %0s record %0d %s is %0h, expected %0h",
                     $time, name, k, field, got, want);
            check_errors++;
        end
    endtask

    // Queue opens one cycle after reset, no record is pending
    task automatic check_reset_exit();
        int errs_before;
        errs_before = check_errors;
        @(negedge clk);
        assert (!fetch_ready && !instr_valid) else begin
            $display("fetch_ready or instr_valid was high in the first cycle after reset");
            check_errors++;
        end
        @(negedge clk);
        assert (fetch_ready) else begin
            $display("fetch_ready did not rise in the second cycle after reset");
            check_errors++;
        end
        @(posedge clk);
        #1;
        if (check_errors == errs_before) begin
            $display("Test reset_exit: ok");
        end else begin
            failed_tests++;
            $display("Test reset_exit: %0d errors", check_errors - errs_before);
        end
    endtask

    // Words go in order, a word once offered stays until taken
    task automatic feed_words(input int first, input int num);
        int i;
        logic hold;
        logic accepted;
        i = 0;
        hold = 1'b0;
        while (i < num) begin
            if (!hold) begin
                fetch_valid = ($urandom % 4) != 0;
            end
            fetch_data = word_q[first + i];
            @(negedge clk);
            accepted = fetch_valid && fetch_ready;
            hold = fetch_valid && !accepted;
            @(posedge clk);
            #1;
            if (accepted) i++;
        end
        fetch_valid = 1'b0;
    endtask

    // Records compared in order, with random holds on instr_ready
    task automatic collect_records(input int t);
        int k;
        logic [14:0] want;
        k = 0;
        while (k < rec_num[t]) begin
            instr_ready = ($urandom % 4) != 0;
            @(negedge clk);
            if (instr_valid && instr_ready) begin
                want = exp_rec[rec_first[t] + k];
                check_field(test_name[t], k, "length", int'(instr_length), int'(want[14:11]));
                check_field(test_name[t], k, "opcode", int'(instr_opcode), int'(want[10:3]));
                check_field(test_name[t], k, "two_byte", int'(instr_two_byte), int'(want[2]));
                check_field(test_name[t], k, "operand_32", int'(instr_operand_32), int'(want[1]));
                check_field(test_name[t], k, "address_32", int'(instr_address_32), int'(want[0]));
                k++;
            end
            @(posedge clk);
            #1;
        end
        instr_ready = 1'b0;
    endtask

    task automatic run_test(input int t);
        int errs_before;
        errs_before = check_errors;
        // Stage is drained here, so the size mode can change
        mode_32bit = test_mode[t];
        fork
            feed_words(word_first[t], word_num[t]);
            collect_records(t);
        join
        // Any further record is a repeat or a stray
        repeat (3) begin
            @(negedge clk);
            assert (!instr_valid) else begin
                $display("Test %0s handed out a record beyond its expected ones", test_name[t]);
                check_errors++;
            end
        end
        @(posedge clk);
        #1;
        if (check_errors == errs_before) begin
            $display("Test %0s: %0d records ok", test_name[t], rec_num[t]);
        end else begin
            failed_tests++;
            $display("Test %0s: %0d errors", test_name[t], check_errors - errs_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        mode_32bit = 1'b0;
        fetch_valid = 1'b0;
        fetch_data = '0;
        instr_ready = 1'b0;
        num_tests = 0;
        check_errors = 0;
        failed_tests = 0;
        load_done = 1'b0;
        seed_val = $urandom(32'hb058);
        load_input();
        load_done = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_reset_exit();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 num_tests, failed_tests, check_errors);
        if (num_tests > 0 && check_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Limit scales with the number of fetch words
    initial begin
        wait (load_done);
        repeat (200 * word_q.size() + 1000) @(posedge clk);
        $display("Timeout: the stage stopped handing out the expected records");
        $display("Result: FAILED");
        $finish;
    end

endmodule
